// ==== all.f ====
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/instr_queue.sv
rtl/fetch_stage.sv
rtl/decode_unit.sv
rtl/fetch_top.sv
test/fetch_tb.sv

// ==== rtl/decode_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

// registered rv32i decode: opcode class, register fields, immediate, order
module decode_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          redirect,
    input  logic                          fetch_valid,
    input  logic [fetch_pkg::xlen-1:0]    fetch_instr,
    input  logic [fetch_pkg::xlen-1:0]    fetch_pc,
    output logic                          fetch_ready,
    output logic                          dec_valid,
    output logic [fetch_pkg::xlen-1:0]    dec_pc,
    output fetch_pkg::op_e                dec_op,
    output logic [4:0]                    dec_rd,
    output logic [4:0]                    dec_rs1,
    output logic [4:0]                    dec_rs2,
    output logic [fetch_pkg::xlen-1:0]    dec_imm,
    output logic [fetch_pkg::order_w-1:0] dec_order
);

    fetch_pkg::op_e                op;
    logic [fetch_pkg::xlen-1:0]    imm;
    logic                          leave;         // current output accepted by the back end
    logic [fetch_pkg::order_w-1:0] order_cnt;
    logic [fetch_pkg::order_w-1:0] order_next;

    assign fetch_ready = !stall || !dec_valid;
    assign leave       = dec_valid && !stall;
    assign order_next  = leave ? order_cnt + 1'b1 : order_cnt;

    always_comb begin
        case (fetch_instr[6:0])
            fetch_pkg::opc_lui:    op = fetch_pkg::op_lui;
            fetch_pkg::opc_auipc:  op = fetch_pkg::op_auipc;
            fetch_pkg::opc_jal:    op = fetch_pkg::op_jal;
            fetch_pkg::opc_jalr:   op = fetch_pkg::op_jalr;
            fetch_pkg::opc_branch: op = fetch_pkg::op_branch;
            fetch_pkg::opc_load:   op = fetch_pkg::op_load;
            fetch_pkg::opc_store:  op = fetch_pkg::op_store;
            fetch_pkg::opc_imm:    op = fetch_pkg::op_imm;
            fetch_pkg::opc_reg:    op = fetch_pkg::op_reg;
            fetch_pkg::opc_system: op = fetch_pkg::op_system;
            default:               op = fetch_pkg::op_illegal;
        endcase
    end

    // immediate by format, sign from bit 31
    always_comb begin
        case (op)
            fetch_pkg::op_lui, fetch_pkg::op_auipc:  // u-type
                imm = {fetch_instr[31:12], 12'h000};
            fetch_pkg::op_jal:                         // j-type
                imm = {{11{fetch_instr[31]}}, fetch_instr[31], fetch_instr[19:12],
                       fetch_instr[20], fetch_instr[30:21], 1'b0};
            fetch_pkg::op_branch:                      // b-type
                imm = {{19{fetch_instr[31]}}, fetch_instr[31], fetch_instr[7],
                       fetch_instr[30:25], fetch_instr[11:8], 1'b0};
            fetch_pkg::op_store:                       // s-type
                imm = {{20{fetch_instr[31]}}, fetch_instr[31:25], fetch_instr[11:7]};
            fetch_pkg::op_jalr, fetch_pkg::op_load,
            fetch_pkg::op_imm, fetch_pkg::op_system:   // i-type
                imm = {{20{fetch_instr[31]}}, fetch_instr[31:20]};
            default:
                imm = '0;                              // r-type and illegal
        endcase
    end

    // order keeps counting across redirects
    always_ff @(posedge clk) begin
        if (rst) begin
            order_cnt <= '0;
        end else begin
            order_cnt <= order_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            dec_valid <= 1'b0;
        end else if (fetch_ready) begin
            dec_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_ready && fetch_valid) begin
            dec_pc    <= fetch_pc;
            dec_op    <= op;
            dec_rd    <= fetch_instr[11:7];
            dec_rs1   <= fetch_instr[19:15];
            dec_rs2   <= fetch_instr[24:20];
            dec_imm   <= imm;
            dec_order <= order_next;               // count of everything already gone
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    localparam int xlen = 32;                          // data and address width
    localparam logic [xlen-1:0] reset_pc = 32'h0000_1000;

    // instruction queue geometry
    localparam int iq_depth = 4;
    localparam int iq_ptr_w = 2;

    localparam int order_w = 64;                       // retire order count

    // rv32i major opcodes, bits [6:0] of the instruction
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_reg    = 7'b0110011;
    localparam logic [6:0] opc_system = 7'b1110011;

    // opcode class seen by the back end
    typedef enum logic [3:0] {
        op_lui     = 4'd0,
        op_auipc   = 4'd1,
        op_jal     = 4'd2,
        op_jalr    = 4'd3,
        op_branch  = 4'd4,
        op_load    = 4'd5,
        op_store   = 4'd6,
        op_imm     = 4'd7,
        op_reg     = 4'd8,
        op_system  = 4'd9,
        op_illegal = 4'd15
    } op_e;

endpackage

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

// memory request side and queue control of the fetch front end
module fetch_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [fetch_pkg::xlen-1:0] pc,
    output logic                       advance,
    // instruction memory
    output logic [fetch_pkg::xlen-1:0] imem_addr,
    output logic [3:0]                 imem_rmask,
    input  logic                       imem_resp,
    input  logic [fetch_pkg::xlen-1:0] imem_rdata,
    input  logic                       redirect,
    // instruction queue
    output logic                       iq_push,
    output logic                       iq_pop,
    output logic                       iq_flush,
    output logic [fetch_pkg::xlen-1:0] iq_wdata_instr,
    output logic [fetch_pkg::xlen-1:0] iq_wdata_pc,
    input  logic                       iq_full,
    input  logic                       iq_empty,
    input  logic [fetch_pkg::xlen-1:0] iq_rdata_instr,
    input  logic [fetch_pkg::xlen-1:0] iq_rdata_pc,
    // toward decode
    output logic                       fetch_valid,
    output logic [fetch_pkg::xlen-1:0] fetch_instr,
    output logic [fetch_pkg::xlen-1:0] fetch_pc,
    input  logic                       fetch_ready
);

    logic                       fetch_en;         // low in reset and the cycle after it
    logic                       redirect_pending; // outstanding request belongs to old path
    logic [fetch_pkg::xlen-1:0] held_addr;        // address of that stale request
    logic                       req_active;
    logic                       resp_keep;

    // the queue cannot fill during a request, it only grows on a response
    assign req_active = fetch_en && !iq_full;
    assign imem_rmask = req_active ? 4'hf : 4'h0;

    // pc already points at the redirect target, keep the old address on the bus
    assign imem_addr = redirect_pending ? held_addr : pc;

    // drop responses to anything issued before a redirect
    assign resp_keep = imem_resp && !redirect && !redirect_pending;
    assign advance   = resp_keep;

    assign iq_push        = resp_keep;
    assign iq_wdata_instr = imem_rdata;
    assign iq_wdata_pc    = imem_addr;
    assign iq_flush       = redirect;

    // the head moves to decode when there is room; on a redirect it is discarded by the flush
    assign iq_pop      = !iq_empty && fetch_ready && !redirect;
    assign fetch_valid = iq_pop;
    assign fetch_instr = iq_rdata_instr;
    assign fetch_pc    = iq_rdata_pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_en         <= 1'b0;
            redirect_pending <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (redirect_pending && imem_resp) begin
                redirect_pending <= 1'b0;          // stale response consumed
            end else if (redirect && req_active && !imem_resp) begin
                redirect_pending <= 1'b1;
            end
        end
    end

    // capture the in-flight address once, a second redirect keeps the first one
    always_ff @(posedge clk) begin
        if (redirect && !redirect_pending) begin
            held_addr <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  logic                          clk,
    input  logic                          rst,
    output logic [fetch_pkg::xlen-1:0]    imem_addr,
    output logic [3:0]                    imem_rmask,
    input  logic                          imem_resp,
    input  logic [fetch_pkg::xlen-1:0]    imem_rdata,
    input  logic                          redirect,
    input  logic [fetch_pkg::xlen-1:0]    redirect_pc,
    input  logic                          stall,
    output logic                          dec_valid,
    output logic [fetch_pkg::xlen-1:0]    dec_pc,
    output fetch_pkg::op_e                dec_op,
    output logic [4:0]                    dec_rd,
    output logic [4:0]                    dec_rs1,
    output logic [4:0]                    dec_rs2,
    output logic [fetch_pkg::xlen-1:0]    dec_imm,
    output logic [fetch_pkg::order_w-1:0] dec_order
);

    logic [fetch_pkg::xlen-1:0] pc;
    logic                       advance;
    logic                       iq_push;
    logic                       iq_pop;
    logic                       iq_flush;
    logic                       iq_full;
    logic                       iq_empty;
    logic [fetch_pkg::xlen-1:0] iq_wdata_instr;
    logic [fetch_pkg::xlen-1:0] iq_wdata_pc;
    logic [fetch_pkg::xlen-1:0] iq_rdata_instr;
    logic [fetch_pkg::xlen-1:0] iq_rdata_pc;
    logic                       fetch_valid;
    logic                       fetch_ready;
    logic [fetch_pkg::xlen-1:0] fetch_instr;
    logic [fetch_pkg::xlen-1:0] fetch_pc;

    pc_gen pc_gen_i (
        .clk         (clk),
        .rst         (rst),
        .advance     (advance),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc)
    );

    fetch_stage fetch_stage_i (
        .clk            (clk),
        .rst            (rst),
        .pc             (pc),
        .advance        (advance),
        .imem_addr      (imem_addr),
        .imem_rmask     (imem_rmask),
        .imem_resp      (imem_resp),
        .imem_rdata     (imem_rdata),
        .redirect       (redirect),
        .iq_push        (iq_push),
        .iq_pop         (iq_pop),
        .iq_flush       (iq_flush),
        .iq_wdata_instr (iq_wdata_instr),
        .iq_wdata_pc    (iq_wdata_pc),
        .iq_full        (iq_full),
        .iq_empty       (iq_empty),
        .iq_rdata_instr (iq_rdata_instr),
        .iq_rdata_pc    (iq_rdata_pc),
        .fetch_valid    (fetch_valid),
        .fetch_instr    (fetch_instr),
        .fetch_pc       (fetch_pc),
        .fetch_ready    (fetch_ready)
    );

    instr_queue #(
        .depth (fetch_pkg::iq_depth)
    ) instr_queue_i (
        .clk         (clk),
        .rst         (rst),
        .push        (iq_push),
        .pop         (iq_pop),
        .flush       (iq_flush),
        .wdata_instr (iq_wdata_instr),
        .wdata_pc    (iq_wdata_pc),
        .rdata_instr (iq_rdata_instr),
        .rdata_pc    (iq_rdata_pc),
        .full        (iq_full),
        .empty       (iq_empty)
    );

    decode_unit decode_unit_i (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .fetch_pc    (fetch_pc),
        .fetch_ready (fetch_ready),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_op      (dec_op),
        .dec_rd      (dec_rd),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_imm     (dec_imm),
        .dec_order   (dec_order)
    );

endmodule

`default_nettype wire

// ==== rtl/instr_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

// circular fifo of (instruction, pc) pairs between fetch and decode
module instr_queue #(
    parameter int depth = fetch_pkg::iq_depth
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  logic                       pop,
    input  logic                       flush,
    input  logic [fetch_pkg::xlen-1:0] wdata_instr,
    input  logic [fetch_pkg::xlen-1:0] wdata_pc,
    output logic [fetch_pkg::xlen-1:0] rdata_instr,
    output logic [fetch_pkg::xlen-1:0] rdata_pc,
    output logic                       full,
    output logic                       empty
);

    logic [fetch_pkg::xlen-1:0] mem_instr [depth];
    logic [fetch_pkg::xlen-1:0] mem_pc    [depth];

    logic [fetch_pkg::iq_ptr_w-1:0] wr_ptr;
    logic [fetch_pkg::iq_ptr_w-1:0] rd_ptr;
    logic [fetch_pkg::iq_ptr_w:0]   count;          // one extra bit to tell full from empty

    logic do_push;
    logic do_pop;

    function automatic logic [fetch_pkg::iq_ptr_w-1:0] ptr_inc(
        input logic [fetch_pkg::iq_ptr_w-1:0] ptr
    );
        if (ptr == fetch_pkg::iq_ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full  = (count == (fetch_pkg::iq_ptr_w + 1)'(depth));
    assign empty = (count == '0);

    assign do_push = push && !full;                 // push into a full queue is dropped
    assign do_pop  = pop && !empty;

    // read side is a plain mux on the read pointer
    assign rdata_instr = mem_instr[rd_ptr];
    assign rdata_pc    = mem_pc[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_instr[wr_ptr] <= wdata_instr;
            mem_pc[wr_ptr]    <= wdata_pc;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pc_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

// fetch address generator, sequential only (no prediction)
module pc_gen (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       advance,      // response accepted and kept
    input  logic                       redirect,
    input  logic [fetch_pkg::xlen-1:0] redirect_pc,
    output logic [fetch_pkg::xlen-1:0] pc
);

    logic [fetch_pkg::xlen-1:0] pc_next;

    always_comb begin
        pc_next = pc;
        if (redirect) begin
            pc_next = redirect_pc;                     // redirect wins over advance
        end else if (advance) begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= fetch_pkg::reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the fetch front end simulation with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -Wno-fatal --top-module fetch_tb \
    -f all.f -Mdir "$build_dir" -o fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/fetch_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the verdict comes from the log
if grep -qx "test passed" "$log_file"; then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1

// ==== test/fetch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;

    localparam int clk_period = 40;
    localparam int n_tests    = 5;
    localparam int img_base   = 'h10;          // word offsets of the sections in the data file
    localparam int redir_base = 'h40;
    localparam int exp_base   = 'h60;

    logic                 clk;
    logic                 rst;
    logic [31:0]          imem_addr;
    logic [3:0]           imem_rmask;
    logic                 imem_resp;
    logic [31:0]          imem_rdata;
    logic                 redirect;
    logic [31:0]          redirect_pc;
    logic                 stall;
    logic                 dec_valid;
    logic [31:0]          dec_pc;
    fetch_pkg::op_e       dec_op;
    logic [4:0]           dec_rd;
    logic [4:0]           dec_rs1;
    logic [4:0]           dec_rs2;
    logic [31:0]          dec_imm;
    logic [63:0]          dec_order;

    logic [31:0] raw        [0:255];
    logic [31:0] mem_image  [0:47];
    logic [31:0] redir_list [0:15][0:1];       // decoded index, target pc
    logic [31:0] exp_list   [0:25][0:5];       // pc, op, rd, rs1, rs2, imm

    int    n_image;
    int    n_redir;
    int    n_exp;
    int    seed = 40;
    int    errors [n_tests];
    string test_name [n_tests];
    int    exp_idx;
    int    redir_ptr;
    int    in_flight;                          // redirects that caught a request in flight
    int    total;

    // memory model
    logic        mem_busy;
    int          mem_wait;
    logic [31:0] mem_addr;

    // back end side
    logic        hold_armed;
    logic        after_redirect;
    logic        expect_target;
    logic [31:0] last_target;

    fetch_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .imem_addr   (imem_addr),
        .imem_rmask  (imem_rmask),
        .imem_resp   (imem_resp),
        .imem_rdata  (imem_rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .stall       (stall),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_op      (dec_op),
        .dec_rd      (dec_rd),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_imm     (dec_imm),
        .dec_order   (dec_order)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_value(input int test, input string name,
                               input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            $display("Mismatch at %0d ns: %s expected %0h, got %0h", $time, name, want, got);
            errors[test]++;
        end
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - fetch_pkg::reset_pc) >> 2;
        if (addr >= fetch_pkg::reset_pc && idx < n_image) begin
            return mem_image[idx];
        end
        return ~addr;                          // outside the image
    endfunction

    task automatic load_testdata();
        $readmemh("test/fetch_testdata.txt", raw);
        n_image = raw[0];
        n_redir = raw[1];
        n_exp   = raw[2];
        for (int i = 0; i < n_image; i++) begin
            mem_image[i] = raw[img_base + i];
        end
        for (int r = 0; r < n_redir; r++) begin
            redir_list[r][0] = raw[redir_base + 2 * r];
            redir_list[r][1] = raw[redir_base + 2 * r + 1];
        end
        for (int e = 0; e < n_exp; e++) begin
            for (int f = 0; f < 6; f++) begin
                exp_list[e][f] = raw[exp_base + 6 * e + f];
            end
        end
    endtask

    // one clock cycle of output checks followed by the memory and back end inputs
    task automatic run_cycle();
        logic stall_next;
        logic accept;
        logic resp_now;
        logic fire;
        @(posedge clk);
        #2;
        resp_now = 1'b0;
        fire     = 1'b0;
        if (hold_armed) begin
            check_value(2, "dec_valid", dec_valid, 64'd1);
            check_value(2, "dec_pc", dec_pc, exp_list[exp_idx][0]);
            check_value(2, "dec_order", dec_order, exp_idx);
            check_value(2, "dec_imm", dec_imm, exp_list[exp_idx][5]);
        end
        if (after_redirect) begin
            check_value(3, "dec_valid", dec_valid, 64'd0);
        end
        after_redirect = 1'b0;
        stall_next = (($random(seed) & 3) == 0);    // about one cycle in four
        accept     = dec_valid && !stall_next;
        hold_armed = dec_valid && stall_next;

        if (mem_busy) begin
            check_value(4, "imem_rmask", imem_rmask, 64'hf);
            check_value(4, "imem_addr", imem_addr, mem_addr);
            mem_wait--;
            if (mem_wait == 0) begin
                resp_now = 1'b1;
                mem_busy = 1'b0;
            end
        end else if (imem_rmask == 4'hf) begin
            mem_busy = 1'b1;
            mem_addr = imem_addr;
            mem_wait = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
        end

        if (accept) begin
            check_value(redir_ptr == 0 ? 0 : 3, "dec_pc", dec_pc, exp_list[exp_idx][0]);
            if (redir_ptr == 0) begin
                check_value(0, "dec_pc", dec_pc, fetch_pkg::reset_pc + 4 * exp_idx);
            end
            if (expect_target) begin
                check_value(3, "dec_pc", dec_pc, last_target);
            end
            expect_target = 1'b0;
            check_value(1, "dec_op", dec_op, exp_list[exp_idx][1]);
            check_value(1, "dec_rd", dec_rd, exp_list[exp_idx][2]);
            check_value(1, "dec_rs1", dec_rs1, exp_list[exp_idx][3]);
            check_value(1, "dec_rs2", dec_rs2, exp_list[exp_idx][4]);
            check_value(1, "dec_imm", dec_imm, exp_list[exp_idx][5]);
            check_value(2, "dec_order", dec_order, exp_idx);
            if (redir_ptr < n_redir && exp_idx == redir_list[redir_ptr][0]) begin
                fire           = 1'b1;
                last_target    = redir_list[redir_ptr][1];
                expect_target  = 1'b1;
                after_redirect = 1'b1;
                if (mem_busy) begin
                    in_flight++;                    // its response has to be dropped
                end
                redir_ptr++;
            end
            exp_idx++;
        end

        stall       = stall_next;
        redirect    = fire;
        redirect_pc = fire ? last_target : redirect_pc;
        imem_resp   = resp_now;
        imem_rdata  = resp_now ? mem_word(mem_addr) : 32'h0;
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        imem_resp      = 1'b0;
        imem_rdata     = 32'h0;
        redirect       = 1'b0;
        redirect_pc    = 32'h0;
        stall          = 1'b0;
        exp_idx        = 0;
        redir_ptr      = 0;
        in_flight      = 0;
        mem_busy       = 1'b0;
        mem_wait       = 0;
        mem_addr       = 32'h0;
        hold_armed     = 1'b0;
        after_redirect = 1'b0;
        expect_target  = 1'b0;
        last_target    = 32'h0;
        for (int t = 0; t < n_tests; t++) begin
            errors[t] = 0;
        end
        test_name[0] = "straight-line fetch";
        test_name[1] = "decode fields";
        test_name[2] = "back-pressure";
        test_name[3] = "redirect";
        test_name[4] = "redirect with request in flight";
        load_testdata();
        if (n_exp == 0) begin
            $display("the data file holds no expected entries");
            errors[0]++;
        end
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        check_value(0, "dec_valid", dec_valid, 64'd0);
        while (exp_idx < n_exp) begin
            run_cycle();
        end
        if (n_redir > 0 && in_flight == 0) begin
            $display("no redirect arrived while a memory request was outstanding");
            errors[4]++;
        end
        total = 0;
        for (int t = 0; t < n_tests; t++) begin
            $display("%s: %s, %0d errors", test_name[t], errors[t] == 0 ? "ok" : "FAIL",
                     errors[t]);
            total += errors[t];
        end
        $display("%0d outputs checked, %0d redirects, %0d in flight, %0d errors",
                 exp_idx, redir_ptr, in_flight, total);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog scaled by the length of the expected stream
    initial begin
        wait (n_exp > 0);
        #(40 * n_exp * clk_period);
        $display("timeout at %0d ns, %0d of %0d outputs seen", $time, exp_idx, n_exp);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/fetch_testdata.txt ====
// fetch front end data, one word array with sections at @ offsets
// @00 counts: image words, redirects, expected entries    @10 memory image from 0x1000
// @40 redirects: decoded index, target pc    @60 expected: pc op rd rs1 rs2 imm
@00
00000010 00000002 00000010
@10
123450B7 FFFFF117 FFF08193 00310233  // lui auipc addi add
0080A283 FE512E23 00208863 FF9FF0EF  // lw sw beq jal
00008067 C0002373 FFFFFFFF 000013B7  // jalr csrrs illegal lui
07F3E413 401404B3 FE019AE3 009402A3  // ori sub bne sb
@40
00000005 00001030
00000009 00001018
@60
00001000 0 01 08 03 12345000
00001004 1 02 1F 1F FFFFF000
00001008 7 03 01 1F FFFFFFFF
0000100C 8 04 02 03 00000000
00001010 5 05 01 08 00000008
00001014 6 1C 02 05 FFFFFFFC
00001030 7 08 07 1F 0000007F
00001034 8 09 08 01 00000000
00001038 4 15 03 00 FFFFFFF4
0000103C 6 05 08 09 00000005
00001018 4 10 01 02 00000010
0000101C 2 01 1F 19 FFFFFFF8
00001020 3 00 01 00 00000000
00001024 9 06 00 00 FFFFFC00
00001028 F 1F 1F 1F 00000000
0000102C 0 07 00 00 00001000
